//--- cpu_consts.svh
//////////////////////////////
// cpu memory side constants
// widths, cache geometry and the I/O select
//////////////////////////////

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address word width
`define CPU_XLEN 32

// one word per instruction cache line
`define CPU_ICACHE_LINES 16

`define CPU_MEM_BYTES 131072

// addr[17:16] value that selects I/O
`define CPU_IO_SEL 3

`endif

//--- cpu_pkg.sv
//////////////////////////////
// cpu shared types
// memory op codes, access size and word view
//////////////////////////////

`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    // load/store operation as issued by the core
    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_t;

    // number of bytes minus one
    typedef logic [1:0] acc_size_t;

    // one bus word, whole or byte by byte (little-endian)
    typedef union packed {
        logic [`CPU_XLEN-1:0]        word;
        logic [`CPU_XLEN/8-1:0][7:0] bytes;
    } mem_word_u;

endpackage

`default_nettype wire

//--- mem_req_if.sv
//////////////////////////////
// memory request port
// one requester to the memory controller
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

interface mem_req_if;
    import cpu_pkg::*;

    // request side, held stable until done
    logic                 req;
    logic                 write;
    acc_size_t            size;
    logic [`CPU_XLEN-1:0] addr;
    logic [`CPU_XLEN-1:0] wdata;

    // one-cycle done, rdata valid with it
    logic                 done;
    mem_word_u            rdata;

    modport requester (output req, write, size, addr, wdata, input done, rdata);
    modport server (input req, write, size, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

//--- inst_fetch.sv
//////////////////////////////
// instruction fetch unit
// direct-mapped icache, miss fill over its port
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module inst_fetch (
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 rdy_in,
    input  logic                 fetch_req,
    input  logic [`CPU_XLEN-1:0] fetch_pc,
    output logic                 fetch_valid,
    output logic [`CPU_XLEN-1:0] fetch_inst,
    mem_req_if.requester         mem
);
    localparam int IDX_W = $clog2(`CPU_ICACHE_LINES);
    localparam int TAG_W = `CPU_XLEN - IDX_W - 2;

    logic [TAG_W-1:0]             tag_q [`CPU_ICACHE_LINES];
    logic [`CPU_XLEN-1:0]         data_q [`CPU_ICACHE_LINES];
    logic [`CPU_ICACHE_LINES-1:0] valid_q;
    logic                         fill_q;
    logic [IDX_W-1:0]             idx;
    logic [TAG_W-1:0]             tag;
    logic                         hit;
    logic                         start;

    assign idx = fetch_pc[IDX_W+1:2];
    assign tag = fetch_pc[`CPU_XLEN-1:IDX_W+2];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // new request only once the previous answer has been seen
    assign start = fetch_req && !fetch_valid && !fill_q;

    // miss fill is always one aligned word
    assign mem.req   = fill_q;
    assign mem.write = 1'b0;
    assign mem.size  = 2'd3;
    assign mem.addr  = fetch_pc;
    assign mem.wdata = '0;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            fill_q      <= 1'b0;
            fetch_valid <= 1'b0;
            valid_q     <= '0;
        end else if (rdy_in) begin
            fetch_valid <= 1'b0;
            if (fill_q) begin
                if (mem.done) begin
                    fill_q       <= 1'b0;
                    fetch_valid  <= 1'b1;
                    valid_q[idx] <= 1'b1;
                end
            end else if (start && !hit) begin
                fill_q <= 1'b1;
            end else if (start) begin
                fetch_valid <= 1'b1;
            end
        end
    end

    // cache arrays and answer word
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (fill_q && mem.done) begin
                tag_q[idx]  <= tag;
                data_q[idx] <= mem.rdata.word;
                fetch_inst  <= mem.rdata.word;
            end else if (start && hit) begin
                fetch_inst <= data_q[idx];
            end
        end
    end

    a_pc_aligned: assert property (@(posedge clk_in) disable iff (!arst_n)
        fetch_req |-> (fetch_pc[1:0] == 2'b00))
        else $error("fetch pc not word aligned");

endmodule

`default_nettype wire

//--- load_store_unit.sv
//////////////////////////////
// load/store unit
// maps ops onto the data port, extends loads
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module load_store_unit (
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 rdy_in,
    input  logic                 ls_req,
    input  cpu_pkg::mem_op_t     ls_op,
    input  logic [`CPU_XLEN-1:0] ls_addr,
    input  logic [`CPU_XLEN-1:0] ls_wdata,
    output logic                 ls_done,
    output logic [`CPU_XLEN-1:0] ls_rdata,
    mem_req_if.requester         mem
);
    import cpu_pkg::*;

    logic                 is_store;
    acc_size_t            size;
    logic [`CPU_XLEN-1:0] rd;
    logic [`CPU_XLEN-1:0] load_val;

    always_comb begin
        is_store = 1'b0;
        size     = 2'd3;
        case (ls_op)
            op_lb, op_lbu: size = 2'd0;
            op_lh, op_lhu: size = 2'd1;
            op_sb: begin
                is_store = 1'b1;
                size     = 2'd0;
            end
            op_sh: begin
                is_store = 1'b1;
                size     = 2'd1;
            end
            op_sw: is_store = 1'b1;
            default: ;
        endcase
    end

    // held off during the done cycle so the same op is not issued twice
    assign mem.req   = ls_req && !ls_done;
    assign mem.write = is_store;
    assign mem.size  = size;
    assign mem.addr  = ls_addr;
    assign mem.wdata = ls_wdata;

    assign rd = mem.rdata.word;

    always_comb begin
        case (ls_op)
            op_lb:   load_val = {{24{rd[7]}}, rd[7:0]};
            op_lh:   load_val = {{16{rd[15]}}, rd[15:0]};
            op_lbu:  load_val = {24'b0, rd[7:0]};
            op_lhu:  load_val = {16'b0, rd[15:0]};
            op_lw:   load_val = rd;
            default: load_val = '0;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            ls_done <= 1'b0;
        end else if (rdy_in) begin
            ls_done <= mem.done;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && mem.done) begin
            ls_rdata <= load_val;
        end
    end

    // size is bytes minus one, so it doubles as the alignment mask
    a_addr_aligned: assert property (@(posedge clk_in) disable iff (!arst_n)
        ls_req |-> ((ls_addr[1:0] & size) == 2'b00))
        else $error("load/store address not aligned to access size");

endmodule

`default_nettype wire

//--- mem_ctrl.sv
//////////////////////////////
// memory controller
// arbitrates fetch and data onto the byte bus
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module mem_ctrl (
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 rdy_in,
    input  logic [7:0]           mem_din,
    output logic [7:0]           mem_dout,
    output logic [`CPU_XLEN-1:0] mem_a,
    output logic                 mem_wr,
    input  logic                 io_buffer_full,
    mem_req_if.server            ifetch,
    mem_req_if.server            data
);
    import cpu_pkg::*;

    logic                 busy_q;
    logic                 grant_data_q;
    logic [2:0]           cnt_q;
    logic                 rd_vld_q;
    logic [1:0]           rd_idx_q;
    mem_word_u            asm_q;
    mem_word_u            rd_word;
    mem_word_u            sel_wdata;
    logic                 sel_write;
    acc_size_t            sel_size;
    logic [`CPU_XLEN-1:0] sel_addr;
    logic [2:0]           last_cnt;
    logic                 byte_phase;
    logic                 done_phase;
    logic                 io_block;

    // granted port holds its fields until done
    assign sel_write      = grant_data_q ? data.write : ifetch.write;
    assign sel_size       = grant_data_q ? data.size : ifetch.size;
    assign sel_addr       = grant_data_q ? data.addr : ifetch.addr;
    assign sel_wdata.word = grant_data_q ? data.wdata : ifetch.wdata;

    // cnt 0..size moves bytes, cnt size+1 is the done cycle
    assign last_cnt   = {1'b0, sel_size};
    assign byte_phase = busy_q && (cnt_q <= last_cnt);
    assign done_phase = busy_q && (cnt_q == last_cnt + 3'd1);

    assign mem_a    = byte_phase ? sel_addr + `CPU_XLEN'(cnt_q) : '0;
    assign mem_dout = sel_wdata.bytes[cnt_q[1:0]];

    // uart side cannot take a byte
    assign io_block = sel_write && io_buffer_full
                      && (mem_a[17:16] == 2'(`CPU_IO_SEL));
    assign mem_wr   = byte_phase && sel_write && !io_block && rdy_in;

    // last byte comes straight off the bus
    always_comb begin
        rd_word = asm_q;
        if (rd_vld_q) begin
            rd_word.bytes[rd_idx_q] = mem_din;
        end
    end

    assign ifetch.done  = done_phase && rdy_in && !grant_data_q;
    assign data.done    = done_phase && rdy_in && grant_data_q;
    assign ifetch.rdata = rd_word;
    assign data.rdata   = rd_word;

    // data port has fixed priority, no preemption once busy
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy_q       <= 1'b0;
            grant_data_q <= 1'b0;
            cnt_q        <= '0;
        end else if (rdy_in) begin
            if (!busy_q) begin
                if (data.req || ifetch.req) begin
                    busy_q       <= 1'b1;
                    grant_data_q <= data.req;
                    cnt_q        <= '0;
                end
            end else if (done_phase) begin
                busy_q <= 1'b0;
            end else if (!io_block) begin
                cnt_q <= cnt_q + 3'd1;
            end
        end
    end

    // memory answers one cycle later whether or not the cpu is paused
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld_q <= 1'b0;
            rd_idx_q <= '0;
        end else begin
            rd_vld_q <= byte_phase && !sel_write;
            rd_idx_q <= cnt_q[1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (!busy_q) begin
            asm_q.word <= '0;
        end
        if (rd_vld_q) begin
            asm_q.bytes[rd_idx_q] <= mem_din;
        end
    end

    // a blocked I/O write keeps its byte address until the buffer drains
    a_io_wait_holds: assert property (@(posedge clk_in) disable iff (!arst_n)
        io_block |=> $stable(mem_a))
        else $error("I/O write address moved while blocked");

    // done only answers a port that still requests
    a_done_to_req: assert property (@(posedge clk_in) disable iff (!arst_n)
        !(ifetch.done && !ifetch.req) && !(data.done && !data.req))
        else $error("done raised to a port without a request");

endmodule

`default_nettype wire

//--- cpu.sv
//////////////////////////////
// cpu memory side top
// fetch, load/store and memory controller
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu (
    input  logic                 clk_in,
    input  logic                 arst_n,
    // pauses everything when low
    input  logic                 rdy_in,
    input  logic [7:0]           mem_din,
    output logic [7:0]           mem_dout,
    output logic [`CPU_XLEN-1:0] mem_a,
    output logic                 mem_wr,
    input  logic                 io_buffer_full,
    input  logic                 fetch_req,
    input  logic [`CPU_XLEN-1:0] fetch_pc,
    output logic                 fetch_valid,
    output logic [`CPU_XLEN-1:0] fetch_inst,
    input  logic                 ls_req,
    input  cpu_pkg::mem_op_t     ls_op,
    input  logic [`CPU_XLEN-1:0] ls_addr,
    input  logic [`CPU_XLEN-1:0] ls_wdata,
    output logic                 ls_done,
    output logic [`CPU_XLEN-1:0] ls_rdata
);
    mem_req_if ifetch_port ();
    mem_req_if data_port ();

    inst_fetch inst_fetch_i (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .rdy_in      (rdy_in),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .mem         (ifetch_port)
    );

    load_store_unit load_store_unit_i (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .rdy_in   (rdy_in),
        .ls_req   (ls_req),
        .ls_op    (ls_op),
        .ls_addr  (ls_addr),
        .ls_wdata (ls_wdata),
        .ls_done  (ls_done),
        .ls_rdata (ls_rdata),
        .mem      (data_port)
    );

    mem_ctrl mem_ctrl_i (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .rdy_in         (rdy_in),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .io_buffer_full (io_buffer_full),
        .ifetch         (ifetch_port),
        .data           (data_port)
    );

endmodule

`default_nettype wire

//--- tb_cpu.sv
//////////////////////////////
// testbench for the cpu memory side
// replays golden records, plain and with stalls
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int TIMEOUT = 400;
    localparam int AW      = $clog2(`CPU_MEM_BYTES);

    logic                 clk_in = 1'b0;
    logic                 arst_n = 1'b0;
    logic                 rdy_in = 1'b1;
    logic [7:0]           mem_din = '0;
    logic [7:0]           mem_dout;
    logic [`CPU_XLEN-1:0] mem_a;
    logic                 mem_wr;
    logic                 io_buffer_full = 1'b0;
    logic                 fetch_req = 1'b0;
    logic [`CPU_XLEN-1:0] fetch_pc = '0;
    logic                 fetch_valid;
    logic [`CPU_XLEN-1:0] fetch_inst;
    logic                 ls_req = 1'b0;
    mem_op_t              ls_op = op_lw;
    logic [`CPU_XLEN-1:0] ls_addr = '0;
    logic [`CPU_XLEN-1:0] ls_wdata = '0;
    logic                 ls_done;
    logic [`CPU_XLEN-1:0] ls_rdata;

    logic [7:0]  mem [`CPU_MEM_BYTES];
    logic [7:0]  io_log [$];
    logic        stall_en = 1'b0;
    logic        io_hold = 1'b0;
    logic [31:0] lfsr = 32'hdddc;
    logic [2:0]  stall_bits = '0;

    string       rec_kind [$];
    string       rec_op [$];
    logic [31:0] rec_addr [$];
    logic [31:0] rec_wdata [$];
    logic [31:0] rec_exp [$];

    cpu cpu_i (.*);

    always #10 clk_in = ~clk_in;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // byte memory, read data one cycle after the address
    always @(posedge clk_in) begin
        mem_din <= mem[mem_a[AW-1:0]];
        if (mem_wr && !rdy_in) begin
            abort_run("memory written while rdy_in was low");
        end else if (mem_wr && mem_a[17:16] == 2'(`CPU_IO_SEL) && io_buffer_full) begin
            abort_run("I/O written while io_buffer_full was high");
        end else if (mem_wr && mem_a[17:16] == 2'(`CPU_IO_SEL)) begin
            io_log.push_back(mem_dout);
        end else if (mem_wr) begin
            mem[mem_a[AW-1:0]] <= mem_dout;
        end
    end

    // pauses and buffer-full from the LFSR when stalls are on
    always @(negedge clk_in) begin
        if (stall_en) begin
            lfsr          = lfsr_step(lfsr);
            stall_bits[0] = lfsr[0];
            lfsr          = lfsr_step(lfsr);
            stall_bits[1] = lfsr[0];
            lfsr          = lfsr_step(lfsr);
            stall_bits[2] = lfsr[0];
        end
        rdy_in         = stall_en ? |stall_bits[1:0] : 1'b1;
        io_buffer_full = stall_en ? stall_bits[2] : io_hold;
    end

    function automatic mem_op_t op_code(input string s);
        mem_op_t op;
        op = op_lw;
        if (s == "lb") begin
            op = op_lb;
        end else if (s == "lh") begin
            op = op_lh;
        end else if (s == "lbu") begin
            op = op_lbu;
        end else if (s == "lhu") begin
            op = op_lhu;
        end else if (s == "sb") begin
            op = op_sb;
        end else if (s == "sh") begin
            op = op_sh;
        end else if (s == "sw") begin
            op = op_sw;
        end
        return op;
    endfunction

    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        string       k;
        string       o;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] e;
        fd = $fopen("cpu_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open cpu_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // skip blank and comment lines
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h", k, o, a, w, e);
                    if (n == 5) begin
                        rec_kind.push_back(k);
                        rec_op.push_back(o);
                        rec_addr.push_back(a);
                        rec_wdata.push_back(w);
                        rec_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic do_fetch(input logic [31:0] pc, output logic [31:0] inst,
                            output int cycles);
        int n;
        @(negedge clk_in);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        cycles    = 0;
        do begin
            @(negedge clk_in);
            cycles++;
        end while (!fetch_valid && cycles < TIMEOUT);
        if (!fetch_valid) begin
            abort_run("timeout waiting for fetch_valid");
        end
        inst      = fetch_inst;
        fetch_req = 1'b0;
        n = 0;
        while (fetch_valid && n < TIMEOUT) begin
            @(negedge clk_in);
            n++;
        end
        if (fetch_valid) begin
            abort_run("timeout waiting for fetch_valid to drop");
        end
    endtask

    task automatic start_ls(input mem_op_t op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        @(negedge clk_in);
        ls_req   = 1'b1;
        ls_op    = op;
        ls_addr  = addr;
        ls_wdata = wdata;
    endtask

    task automatic wait_ls(output logic [31:0] rdata);
        int n;
        n = 0;
        do begin
            @(negedge clk_in);
            n++;
        end while (!ls_done && n < TIMEOUT);
        if (!ls_done) begin
            abort_run("timeout waiting for ls_done");
        end
        rdata  = ls_rdata;
        ls_req = 1'b0;
        n = 0;
        while (ls_done && n < TIMEOUT) begin
            @(negedge clk_in);
            n++;
        end
        if (ls_done) begin
            abort_run("timeout waiting for ls_done to drop");
        end
    endtask

    // load raised a cycle after the fetch so both ports request together on a miss
    // ls_first tells which finished first
    task automatic run_pair(input logic [31:0] pc, input mem_op_t op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] inst,
                            output logic [31:0] rdata, output logic ls_first);
        int n;
        int f_at;
        int l_at;
        @(negedge clk_in);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        @(negedge clk_in);
        ls_req    = 1'b1;
        ls_op     = op;
        ls_addr   = addr;
        ls_wdata  = wdata;
        n    = 0;
        f_at = 0;
        l_at = 0;
        while ((f_at == 0 || l_at == 0) && n < TIMEOUT) begin
            n++;
            if (f_at == 0 && fetch_valid) begin
                f_at      = n;
                inst      = fetch_inst;
                fetch_req = 1'b0;
            end
            if (l_at == 0 && ls_done) begin
                l_at   = n;
                rdata  = ls_rdata;
                ls_req = 1'b0;
            end
            @(negedge clk_in);
        end
        if (f_at == 0 || l_at == 0) begin
            abort_run("timeout waiting for the paired fetch and load");
        end
        ls_first = l_at < f_at;
        n = 0;
        while ((fetch_valid || ls_done) && n < TIMEOUT) begin
            @(negedge clk_in);
            n++;
        end
        if (fetch_valid || ls_done) begin
            abort_run("timeout waiting for the paired done flags to drop");
        end
    endtask

    task automatic run_records(input logic stalled);
        logic [31:0] got;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] pc_pend;
        logic [31:0] exp_pend;
        logic        pend;
        logic        ls_first;
        int          cycles;
        string       name;
        pend = 1'b0;
        for (int i = 0; i < rec_kind.size(); i++) begin
            a    = rec_addr[i];
            name = $sformatf("%s %s %h", rec_kind[i], rec_op[i], a);
            if (rec_kind[i] == "pre") begin
                for (int b = 0; b < 4; b++) begin
                    mem[a + b] = rec_wdata[i][8*b +: 8];
                end
            end else if (rec_kind[i] == "fetch") begin
                do_fetch(a, got, cycles);
                check_value(name, rec_exp[i], got);
                // latency only holds without pauses
                if (!stalled && rec_op[i] == "hit") begin
                    check_value({name, " latency"}, 1, cycles);
                end
                if (!stalled && rec_op[i] == "miss") begin
                    check_value({name, " slower than a hit"}, 1, cycles > 1);
                end
            end else if (rec_kind[i] == "pair") begin
                pend     = 1'b1;
                pc_pend  = a;
                exp_pend = rec_exp[i];
            end else if (rec_kind[i] == "load" || rec_kind[i] == "store") begin
                if (pend) begin
                    run_pair(pc_pend, op_code(rec_op[i]), a, rec_wdata[i], inst, got, ls_first);
                    check_value($sformatf("pair fetch %h", pc_pend), exp_pend, inst);
                    if (!stalled) begin
                        check_value({name, " done before fetch"}, 1, ls_first);
                    end
                    pend = 1'b0;
                end else begin
                    start_ls(op_code(rec_op[i]), a, rec_wdata[i]);
                    wait_ls(got);
                end
                if (rec_kind[i] == "load") begin
                    check_value(name, rec_exp[i], got);
                end
            end else if (rec_kind[i] == "mem") begin
                check_value(name, rec_exp[i], {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]});
            end else if (rec_kind[i] == "io") begin
                if (!stalled) begin
                    // buffer full a cycle ahead of the request
                    io_hold = 1'b1;
                    @(negedge clk_in);
                    start_ls(op_code(rec_op[i]), a, rec_wdata[i]);
                    repeat (6) begin
                        @(negedge clk_in);
                        check_value({name, " done while full"}, 0, ls_done);
                        check_value({name, " write while full"}, 0, io_log.size());
                    end
                    io_hold = 1'b0;
                end else begin
                    start_ls(op_code(rec_op[i]), a, rec_wdata[i]);
                end
                wait_ls(got);
                check_value({name, " log count"}, 1, io_log.size());
                check_value(name, rec_exp[i], io_log.pop_front());
            end
        end
    endtask

    initial begin
        // fill mixes all address bits
        for (int i = 0; i < `CPU_MEM_BYTES; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
        end
        read_golden();
        repeat (2) @(negedge clk_in);
        arst_n = 1'b1;
        run_records(1'b0);
        $display("golden records matched without stalls");
        stall_en = 1'b1;
        run_records(1'b1);
        stall_en = 1'b0;
        repeat (2) @(negedge clk_in);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu.f
+incdir+.
cpu_pkg.sv
mem_req_if.sv
inst_fetch.sv
load_store_unit.sv
mem_ctrl.sv
cpu.sv
tb_cpu.sv

//--- cpu_golden.txt
# kind op addr wdata expect, all numbers hex; kinds pre fetch pair load store mem io
# pre writes a little-endian word, a pair fetch runs together with the next load
pre - 00001000 00000013 00000000
pre - 00001004 12345678 00000000
pre - 00001008 fedcba98 00000000
pre - 00002000 8091a2f3 00000000
pre - 00002004 7f5a3c41 00000000
pre - 00003000 11223344 00000000
pre - 00003004 55667788 00000000
fetch miss 00001000 00000000 00000013
fetch hit 00001000 00000000 00000013
fetch miss 00001004 00000000 12345678
fetch hit 00001004 00000000 12345678
load lb 00002000 00000000 fffffff3
load lbu 00002000 00000000 000000f3
load lb 00002001 00000000 ffffffa2
load lh 00002000 00000000 ffffa2f3
load lhu 00002002 00000000 00008091
load lh 00002006 00000000 00007f5a
load lb 00002004 00000000 00000041
load lw 00002000 00000000 8091a2f3
store sb 00003001 123456aa 00000000
store sh 00003002 9999beef 00000000
load lw 00003000 00000000 beefaa44
mem - 00003000 00000000 beefaa44
store sw 00003004 cafef00d 00000000
load lw 00003004 00000000 cafef00d
mem - 00003004 00000000 cafef00d
pair miss 00001008 00000000 fedcba98
load lw 00002004 00000000 7f5a3c41
io sb 00030000 00000041 00000041
io sb 00030010 0000005a 0000005a
